//--- hw/rbus_pkg.sv
//////////////////////////////////////////////////
// default shape of the simple register bus
// widths here are defaults only, the top overrides
// resync depth below 2 is not supported
//////////////////////////////////////////////////
`default_nettype none

package rbus_pkg;

	// address bus, 16 registers max
	localparam int RBUS_ADDR_W = 4;	// address width in bits

	// data bus
	localparam int RBUS_DATA_W = 8;	// read and write data width

	// input resync chain depth
	localparam int RBUS_SYNC_W = 2;	// 2 is the minimum for metastability

endpackage

`default_nettype wire

//--- hw/reg_map_pkg.sv
//////////////////////////////////////////////////
// register map of the peripheral register set
// masks: 1 = live bit, 0 = dead bit reads zero
// sized for the default rbus data width
//////////////////////////////////////////////////
`default_nettype none

package reg_map_pkg;

	import rbus_pkg::*;

	// CTRL, read/write latch, bits 3..0 are irq enables
	localparam logic [RBUS_ADDR_W-1:0] CTRL_ADDR    = RBUS_ADDR_W'(0);
	localparam logic [RBUS_DATA_W-1:0] CTRL_WR_MASK = {RBUS_DATA_W{1'b1}};	// all live
	localparam logic [RBUS_DATA_W-1:0] CTRL_RST     = RBUS_DATA_W'(8'h00);	// irqs off

	// STAT, read-only view of status levels
	localparam logic [RBUS_ADDR_W-1:0] STAT_ADDR      = RBUS_ADDR_W'(1);
	localparam logic [RBUS_DATA_W-1:0] STAT_RD_MASK   = {RBUS_DATA_W{1'b1}};	// all live
	localparam logic [RBUS_DATA_W-1:0] STAT_SYNC_MASK = {RBUS_DATA_W{1'b1}};	// async source

	// IRQ, flags set on rising edge, write one to clear
	localparam logic [RBUS_ADDR_W-1:0] IRQ_ADDR      = RBUS_ADDR_W'(2);
	localparam logic [RBUS_DATA_W-1:0] IRQ_MASK      = RBUS_DATA_W'(8'h0F);	// 4 sources
	localparam logic [RBUS_DATA_W-1:0] IRQ_RISE_MASK = RBUS_DATA_W'(8'h0F);	// rise only

	// EVNT, sticky event flags, cleared by a read
	localparam logic [RBUS_ADDR_W-1:0] EVNT_ADDR      = RBUS_ADDR_W'(3);
	localparam logic [RBUS_DATA_W-1:0] EVNT_MASK      = {RBUS_DATA_W{1'b1}};	// all live
	localparam logic [RBUS_DATA_W-1:0] EVNT_SYNC_MASK = {RBUS_DATA_W{1'b1}};	// async source

endpackage

`default_nettype wire

//--- hw/in_cond.sv
//////////////////////////////////////////////////
// per-bit input conditioning
// dead bits give zero, live bits may be resynced
// and then edge detected into a one clock pulse
// SYNC_W must be 2 or more
// an input already high at reset end counts as a rise
//////////////////////////////////////////////////
`default_nettype none

module in_cond #(
	parameter int                DATA_W    = rbus_pkg::RBUS_DATA_W,	// data width
	parameter int                SYNC_W    = rbus_pkg::RBUS_SYNC_W,	// resync stages
	parameter logic [DATA_W-1:0] LIVE_MASK = '1,	// 1 = live bit
	parameter logic [DATA_W-1:0] SYNC_MASK = '0,	// 1 = resync this bit
	parameter logic [DATA_W-1:0] RISE_MASK = '0,	// 1 = rising edge pulse
	parameter logic [DATA_W-1:0] FALL_MASK = '0	// 1 = falling edge pulse
) (
	input  logic              clk_i,
	input  logic              rst_i,	// async, active high
	input  logic [DATA_W-1:0] data_i,	// raw register side input
	output logic [DATA_W-1:0] data_o	// conditioned level or pulse
);

	genvar i;

	generate
		for (i = 0; i < DATA_W; i++) begin : g_bit
			if (LIVE_MASK[i]) begin : g_live
				logic lvl;	// level after optional resync

				if (SYNC_MASK[i]) begin : g_sync
					logic [SYNC_W-1:0] sync_r;	// shift chain, msb is oldest

					always_ff @(posedge clk_i or posedge rst_i) begin
						if (rst_i) begin
							sync_r <= '0;
						end else begin
							sync_r <= {sync_r[SYNC_W-2:0], data_i[i]};	// shift in
						end
					end
					assign lvl = sync_r[SYNC_W-1];
				end else begin : g_raw
					assign lvl = data_i[i];	// already in this clock domain
				end

				if (RISE_MASK[i] || FALL_MASK[i]) begin : g_edge
					logic lvl_d;	// level one clock ago

					always_ff @(posedge clk_i or posedge rst_i) begin
						if (rst_i) begin
							lvl_d <= 1'b0;
						end else begin
							lvl_d <= lvl;
						end
					end

					if (RISE_MASK[i] && FALL_MASK[i]) begin : g_any
						assign data_o[i] = lvl ^ lvl_d;	// any change
					end else if (RISE_MASK[i]) begin : g_rise
						assign data_o[i] = lvl & ~lvl_d;	// 0 -> 1
					end else begin : g_fall
						assign data_o[i] = ~lvl & lvl_d;	// 1 -> 0
					end
				end else begin : g_level
					assign data_o[i] = lvl;	// no edge mask, pass the level
				end
			end else begin : g_dead
				assign data_o[i] = 1'b0;
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- hw/hive_base_reg.sv
//////////////////////////////////////////////////
// one rbus register, write and read modes chosen
// by parameter, masks select live bits per side
// read data is zero unless the address matched
// the cycle before, rbus_rd_i does not gate it
// unknown modes read and write as all zero
//////////////////////////////////////////////////
`default_nettype none

module hive_base_reg #(
	parameter int                DATA_W    = rbus_pkg::RBUS_DATA_W,	// data width
	parameter int                ADDR_W    = rbus_pkg::RBUS_ADDR_W,	// address width
	parameter int                SYNC_W    = rbus_pkg::RBUS_SYNC_W,	// resync stages
	parameter logic [ADDR_W-1:0] ADDR      = '0,	// decoded address
	parameter                    WR_MODE   = "THRU",	// LOOP THRU REGS LTCH COW1
	parameter                    RD_MODE   = "THRU",	// LOOP THRU REGS LTCH CORD
	parameter logic [DATA_W-1:0] WR_MASK   = '1,	// 1 = live write bit
	parameter logic [DATA_W-1:0] RD_MASK   = '1,	// 1 = live read bit
	parameter logic [DATA_W-1:0] SYNC_MASK = '0,	// resync of reg_data_i
	parameter logic [DATA_W-1:0] RISE_MASK = '0,	// rising edge detect
	parameter logic [DATA_W-1:0] FALL_MASK = '0,	// falling edge detect
	parameter logic [DATA_W-1:0] RESET_VAL = '0	// reset of held bits
) (
	input  logic              clk_i,
	input  logic              rst_i,	// async, active high
	input  logic [ADDR_W-1:0] rbus_addr_i,
	input  logic              rbus_wr_i,	// write strobe
	input  logic              rbus_rd_i,	// read strobe
	input  logic [DATA_W-1:0] rbus_wr_data_i,
	output logic [DATA_W-1:0] rbus_rd_data_o,	// zero when not addressed
	output logic              reg_wr_o,	// high when reg_data_o was updated
	output logic              reg_rd_o,	// high when reg_data_i is taken
	output logic [DATA_W-1:0] reg_data_o,	// write side value
	input  logic [DATA_W-1:0] reg_data_i	// register side input
);

	// conditioning follows the side that consumes reg_data_i
	localparam logic [DATA_W-1:0] IN_MASK = (WR_MODE == "COW1") ? WR_MASK : RD_MASK;

	logic              addr_match;	// address decode, this cycle
	logic              addr_f;	// address decode, last cycle
	logic              wr_match;	// qualified write
	logic              rd_match;	// qualified read
	logic              rd_f;	// read strobe seen by read path
	logic [DATA_W-1:0] in_data;	// conditioned reg_data_i
	logic [DATA_W-1:0] wr_data;	// write path result
	logic [DATA_W-1:0] rd_data;	// read path result

	genvar i;

	in_cond #(
		.DATA_W    (DATA_W),
		.SYNC_W    (SYNC_W),
		.LIVE_MASK (IN_MASK),
		.SYNC_MASK (SYNC_MASK),
		.RISE_MASK (RISE_MASK),
		.FALL_MASK (FALL_MASK)
	) u_in_cond (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.data_i (reg_data_i),
		.data_o (in_data)
	);

	assign addr_match = (rbus_addr_i == ADDR);
	assign wr_match   = rbus_wr_i & addr_match;
	assign rd_match   = rbus_rd_i & addr_match;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			addr_f <= 1'b0;
		end else begin
			addr_f <= addr_match;	// one clock read latency
		end
	end

	generate
		// write strobe, late by a clock for the clocked modes
		if (WR_MODE == "REGS" || WR_MODE == "LTCH" || WR_MODE == "COW1") begin : g_wr_clk
			always_ff @(posedge clk_i or posedge rst_i) begin
				if (rst_i) begin
					reg_wr_o <= 1'b0;
				end else begin
					reg_wr_o <= wr_match;
				end
			end
		end else begin : g_wr_comb
			assign reg_wr_o = wr_match;
		end

		// read strobe, CORD gets an extra stage so the bus sees the flags first
		if (RD_MODE == "CORD") begin : g_rd_cord
			always_ff @(posedge clk_i or posedge rst_i) begin
				if (rst_i) begin
					rd_f     <= 1'b0;
					reg_rd_o <= 1'b0;
				end else begin
					rd_f     <= rd_match;	// clears flags next edge
					reg_rd_o <= rd_f;
				end
			end
		end else if (RD_MODE == "REGS" || RD_MODE == "LTCH") begin : g_rd_clk
			assign rd_f = rd_match;
			always_ff @(posedge clk_i or posedge rst_i) begin
				if (rst_i) begin
					reg_rd_o <= 1'b0;
				end else begin
					reg_rd_o <= rd_match;
				end
			end
		end else begin : g_rd_comb
			assign rd_f     = rd_match;
			assign reg_rd_o = rd_match;
		end
	endgenerate

	generate
		for (i = 0; i < DATA_W; i++) begin : g_wr_bit
			if (!WR_MASK[i]) begin : g_dead
				assign wr_data[i] = 1'b0;
			end else if (WR_MODE == "LOOP") begin : g_loop
				assign wr_data[i] = rd_data[i];	// mirrors the read side
			end else if (WR_MODE == "THRU") begin : g_thru
				assign wr_data[i] = rbus_wr_data_i[i];
			end else if (WR_MODE == "REGS" || WR_MODE == "LTCH" || WR_MODE == "COW1") begin : g_held
				logic wr_q;

				always_ff @(posedge clk_i or posedge rst_i) begin
					if (rst_i) begin
						wr_q <= RESET_VAL[i];
					end else if (WR_MODE == "REGS") begin
						wr_q <= rbus_wr_data_i[i];	// every clock
					end else if (WR_MODE == "LTCH") begin
						if (wr_match) begin
							wr_q <= rbus_wr_data_i[i];
						end
					end else begin
						// set wins over a same-cycle clear
						wr_q <= (wr_q & ~(wr_match & rbus_wr_data_i[i])) | in_data[i];
					end
				end
				assign wr_data[i] = wr_q;
			end else begin : g_bad
				assign wr_data[i] = 1'b0;
			end
		end

		for (i = 0; i < DATA_W; i++) begin : g_rd_bit
			if (!RD_MASK[i]) begin : g_dead
				assign rd_data[i] = 1'b0;
			end else if (RD_MODE == "LOOP") begin : g_loop
				assign rd_data[i] = wr_data[i];	// read back what was written
			end else if (RD_MODE == "THRU") begin : g_thru
				assign rd_data[i] = in_data[i];
			end else if (RD_MODE == "REGS" || RD_MODE == "LTCH" || RD_MODE == "CORD") begin : g_held
				logic rd_q;

				always_ff @(posedge clk_i or posedge rst_i) begin
					if (rst_i) begin
						rd_q <= RESET_VAL[i];
					end else if (RD_MODE == "REGS") begin
						rd_q <= in_data[i];
					end else if (RD_MODE == "LTCH") begin
						if (rd_f) begin
							rd_q <= in_data[i];
						end
					end else if (rd_f) begin
						rd_q <= in_data[i];	// clear, keep a new event
					end else begin
						rd_q <= rd_q | in_data[i];	// sticky
					end
				end
				assign rd_data[i] = rd_q;
			end else begin : g_bad
				assign rd_data[i] = 1'b0;
			end
		end
	endgenerate

	assign reg_data_o     = wr_data;
	assign rbus_rd_data_o = addr_f ? rd_data : '0;	// zero so the top can OR

endmodule

`default_nettype wire

//--- hw/periph_regs.sv
//////////////////////////////////////////////////
// peripheral register set on rbus
// CTRL rw, STAT ro, IRQ w1c, EVNT clear on read
// read data one clock after the address
// irq_o is combinational from flags and enables
//////////////////////////////////////////////////
`default_nettype none

module periph_regs #(
	parameter int DATA_W = rbus_pkg::RBUS_DATA_W,	// data width
	parameter int ADDR_W = rbus_pkg::RBUS_ADDR_W,	// address width
	parameter int SYNC_W = rbus_pkg::RBUS_SYNC_W	// resync stages
) (
	input  logic              clk_i,
	input  logic              rst_i,	// async, active high
	input  logic [ADDR_W-1:0] rbus_addr_i,
	input  logic              rbus_wr_i,
	input  logic              rbus_rd_i,
	input  logic [DATA_W-1:0] rbus_wr_data_i,
	output logic [DATA_W-1:0] rbus_rd_data_o,
	output logic [DATA_W-1:0] ctrl_o,	// control latch, 3..0 irq enables
	output logic              ctrl_wr_o,	// pulse after a CTRL write
	input  logic [DATA_W-1:0] stat_i,	// async status levels
	input  logic [DATA_W-1:0] irq_src_i,	// async irq sources
	input  logic [DATA_W-1:0] evnt_i,	// async event levels
	output logic              irq_o	// any enabled flag set
);

	import reg_map_pkg::*;

	logic [DATA_W-1:0] ctrl_rd;	// per register read data, zero when idle
	logic [DATA_W-1:0] stat_rd;
	logic [DATA_W-1:0] irq_rd;
	logic [DATA_W-1:0] evnt_rd;
	logic [DATA_W-1:0] irq_flags;	// IRQ write side, the flags

	hive_base_reg #(
		.DATA_W (DATA_W), .ADDR_W (ADDR_W), .SYNC_W (SYNC_W),
		.ADDR      (CTRL_ADDR),
		.WR_MODE   ("LTCH"),
		.RD_MODE   ("LOOP"),
		.WR_MASK   (CTRL_WR_MASK),
		.RD_MASK   (CTRL_WR_MASK),	// reads back every written bit
		.RESET_VAL (CTRL_RST)
	) u_ctrl (
		.clk_i, .rst_i, .rbus_addr_i, .rbus_wr_i, .rbus_rd_i, .rbus_wr_data_i,
		.rbus_rd_data_o (ctrl_rd),
		.reg_wr_o       (ctrl_wr_o),
		.reg_rd_o       (),
		.reg_data_o     (ctrl_o),
		.reg_data_i     ('0)	// no register side input
	);

	hive_base_reg #(
		.DATA_W (DATA_W), .ADDR_W (ADDR_W), .SYNC_W (SYNC_W),
		.ADDR      (STAT_ADDR),
		.WR_MODE   ("LOOP"),
		.RD_MODE   ("THRU"),
		.WR_MASK   ('0),	// read only
		.RD_MASK   (STAT_RD_MASK),
		.SYNC_MASK (STAT_SYNC_MASK)
	) u_stat (
		.clk_i, .rst_i, .rbus_addr_i, .rbus_wr_i, .rbus_rd_i, .rbus_wr_data_i,
		.rbus_rd_data_o (stat_rd),
		.reg_wr_o       (),
		.reg_rd_o       (),
		.reg_data_o     (),
		.reg_data_i     (stat_i)
	);

	hive_base_reg #(
		.DATA_W (DATA_W), .ADDR_W (ADDR_W), .SYNC_W (SYNC_W),
		.ADDR      (IRQ_ADDR),
		.WR_MODE   ("COW1"),
		.RD_MODE   ("LOOP"),
		.WR_MASK   (IRQ_MASK),
		.RD_MASK   (IRQ_MASK),
		.SYNC_MASK (IRQ_MASK),	// every live source is async
		.RISE_MASK (IRQ_RISE_MASK)
	) u_irq (
		.clk_i, .rst_i, .rbus_addr_i, .rbus_wr_i, .rbus_rd_i, .rbus_wr_data_i,
		.rbus_rd_data_o (irq_rd),
		.reg_wr_o       (),
		.reg_rd_o       (),
		.reg_data_o     (irq_flags),
		.reg_data_i     (irq_src_i)
	);

	hive_base_reg #(
		.DATA_W (DATA_W), .ADDR_W (ADDR_W), .SYNC_W (SYNC_W),
		.ADDR      (EVNT_ADDR),
		.WR_MODE   ("THRU"),
		.RD_MODE   ("CORD"),
		.WR_MASK   ('0),	// writes ignored
		.RD_MASK   (EVNT_MASK),
		.SYNC_MASK (EVNT_SYNC_MASK)
	) u_evnt (
		.clk_i, .rst_i, .rbus_addr_i, .rbus_wr_i, .rbus_rd_i, .rbus_wr_data_i,
		.rbus_rd_data_o (evnt_rd),
		.reg_wr_o       (),
		.reg_rd_o       (),
		.reg_data_o     (),
		.reg_data_i     (evnt_i)
	);

	assign rbus_rd_data_o = ctrl_rd | stat_rd | irq_rd | evnt_rd;	// only one is non zero
	assign irq_o          = |(irq_flags & ctrl_o);	// dead flag bits mask the upper enables

endmodule

`default_nettype wire

//--- tests/periph_regs_checker.sv
//////////////////////////////////////////////////
// bus and interrupt assertions for periph_regs
// attached by bind from the testbench top
// map addresses and masks from reg_map_pkg
//////////////////////////////////////////////////
`default_nettype none

module periph_regs_checker #(
	parameter int DATA_W = rbus_pkg::RBUS_DATA_W,	// data width
	parameter int ADDR_W = rbus_pkg::RBUS_ADDR_W	// address width
) (
	input logic              clk_i,
	input logic              rst_i,
	input logic [ADDR_W-1:0] rbus_addr_i,
	input logic              rbus_wr_i,
	input logic [DATA_W-1:0] rbus_rd_data_o,
	input logic [DATA_W-1:0] ctrl_o,
	input logic              ctrl_wr_o,
	input logic              irq_o
);
	timeunit 1ns;
	timeprecision 1ps;

	import reg_map_pkg::*;

	int   n_fail = 0;	// count of failed assertions
	logic unmapped;	// address hits none of the four registers
	logic ctrl_wr_sel;	// write aimed at CTRL

	assign unmapped    = (rbus_addr_i != CTRL_ADDR) && (rbus_addr_i != STAT_ADDR) &&
	                     (rbus_addr_i != IRQ_ADDR) && (rbus_addr_i != EVNT_ADDR);
	assign ctrl_wr_sel = rbus_wr_i && (rbus_addr_i == CTRL_ADDR);

	a_unmapped_zero: assert property (@(posedge clk_i) disable iff (rst_i)
		unmapped |=> (rbus_rd_data_o == '0))
	else begin
		n_fail++;
		$error("read data not zero after an unmapped address");
	end

	a_ctrl_wr_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		ctrl_wr_o == $past(ctrl_wr_sel))	// one cycle late, exactly once
	else begin
		n_fail++;
		$error("ctrl_wr_o does not follow a CTRL write");
	end

	a_irq_masked: assert property (@(posedge clk_i) disable iff (rst_i)
		((ctrl_o & IRQ_MASK) == '0) |-> !irq_o)	// interrupt needs an enable
	else begin
		n_fail++;
		$error("irq_o high with all enables off");
	end

endmodule

`default_nettype wire

//--- tests/periph_regs_tb.sv
//////////////////////////////////////////////////
// directed testbench for periph_regs
// inputs change on the rising edge, outputs are
// sampled on the falling edge
// runs at the default widths of rbus_pkg
// random values come from a fixed seed
//////////////////////////////////////////////////
`default_nettype none

module periph_regs_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rbus_pkg::*;
	import reg_map_pkg::*;

	localparam int DATA_W   = RBUS_DATA_W;
	localparam int ADDR_W   = RBUS_ADDR_W;
	localparam int POLL_MAX = 20;	// reads before a poll gives up

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;

	localparam addr_t IDLE_ADDR = '1;	// outside the map

	logic  clk_i;
	logic  rst_i;
	addr_t rbus_addr_i;
	logic  rbus_wr_i;
	logic  rbus_rd_i;
	data_t rbus_wr_data_i;
	data_t rbus_rd_data_o;
	data_t ctrl_o;
	logic  ctrl_wr_o;
	data_t stat_i;
	data_t irq_src_i;
	data_t evnt_i;
	logic  irq_o;

	integer seed;	// $random state
	int     n_checks = 0;
	int     n_errors = 0;

	periph_regs #(
		.DATA_W (DATA_W),
		.ADDR_W (ADDR_W),
		.SYNC_W (RBUS_SYNC_W)
	) i_dut (
		.clk_i, .rst_i, .rbus_addr_i, .rbus_wr_i, .rbus_rd_i, .rbus_wr_data_i,
		.rbus_rd_data_o, .ctrl_o, .ctrl_wr_o, .stat_i, .irq_src_i, .evnt_i, .irq_o
	);

	bind periph_regs periph_regs_checker #(
		.DATA_W (DATA_W),
		.ADDR_W (ADDR_W)
	) u_checker (
		.clk_i, .rst_i, .rbus_addr_i, .rbus_wr_i, .rbus_rd_data_o,
		.ctrl_o, .ctrl_wr_o, .irq_o
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;	// 8 ns period
	end

	task automatic check_data(input string name, input data_t got, input data_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		if (n_errors == err_start) begin
			$display("%-20s passed", name);
		end else begin
			$display("%-20s failed with %0d errors", name, n_errors - err_start);
		end
	endtask

	task automatic bus_write(input addr_t addr, input data_t data);
		@(posedge clk_i);
		rbus_addr_i    <= addr;
		rbus_wr_data_i <= data;
		rbus_wr_i      <= 1'b1;
		@(posedge clk_i);	// write taken on this edge
		rbus_wr_i      <= 1'b0;
		rbus_addr_i    <= IDLE_ADDR;
	endtask

	task automatic bus_read(input addr_t addr, output data_t data);
		@(posedge clk_i);
		rbus_addr_i <= addr;
		rbus_rd_i   <= 1'b1;
		@(posedge clk_i);	// data valid from here to the next edge
		rbus_rd_i   <= 1'b0;
		rbus_addr_i <= IDLE_ADDR;
		@(negedge clk_i);
		data = rbus_rd_data_o;
	endtask

	// reads until every bit of want is set
	task automatic poll_read(input addr_t addr, input data_t want, input string what,
	                         output data_t data);
		int tries;
		tries = 0;
		bus_read(addr, data);
		while (((data & want) != want) && (tries < POLL_MAX)) begin
			tries++;
			bus_read(addr, data);
		end
		if ((data & want) != want) begin
			n_errors++;
			$display("timeout: %s did not show up within %0d reads", what, POLL_MAX);
		end
	endtask

	task automatic reset_values();
		int    err_start;
		data_t got;
		err_start = n_errors;
		@(negedge clk_i);
		check_data("rbus_rd_data_o", rbus_rd_data_o, '0);
		bus_read(CTRL_ADDR, got);
		check_data("CTRL read", got, CTRL_RST & CTRL_WR_MASK);
		bus_read(STAT_ADDR, got);
		check_data("STAT read", got, '0);	// stat_i held low
		bus_read(IRQ_ADDR, got);
		check_data("IRQ read", got, '0);
		bus_read(EVNT_ADDR, got);
		check_data("EVNT read", got, '0);
		check_bit("ctrl_wr_o", ctrl_wr_o, 1'b0);
		check_bit("irq_o", irq_o, 1'b0);
		report_test("reset values", err_start);
	endtask

	task automatic ctrl_rw();
		int    err_start;
		int    pulses;
		int    n;
		data_t val;
		data_t got;
		err_start = n_errors;
		pulses    = 0;
		val       = data_t'($random(seed));
		bus_write(CTRL_ADDR, val);
		for (n = 0; n < 4; n++) begin	// pulse window after the write edge
			@(negedge clk_i);
			if (ctrl_wr_o) begin
				pulses++;
			end
		end
		n_checks++;
		if (pulses != 1) begin
			n_errors++;
			$display("ctrl_wr_o pulsed %0d times after one write instead of once", pulses);
		end
		check_data("ctrl_o", ctrl_o, val & CTRL_WR_MASK);
		bus_read(CTRL_ADDR, got);
		check_data("CTRL read", got, val & CTRL_WR_MASK);
		bus_read(addr_t'(9), got);	// no register here
		check_data("unmapped read", got, '0);
		report_test("CTRL read/write", err_start);
	endtask

	task automatic stat_ro();
		int    err_start;
		data_t val;
		data_t got;
		err_start = n_errors;
		val       = data_t'($random(seed));
		@(posedge clk_i);
		stat_i <= val;
		poll_read(STAT_ADDR, val & STAT_RD_MASK, "STAT value", got);
		check_data("STAT read", got, val & STAT_RD_MASK);
		bus_write(STAT_ADDR, ~val);	// must be ignored
		bus_read(STAT_ADDR, got);
		check_data("STAT after write", got, val & STAT_RD_MASK);
		report_test("STAT read only", err_start);
	endtask

	task automatic irq_set_clear();
		int    err_start;
		int    k;
		data_t irq_bit;
		data_t got;
		err_start = n_errors;
		k         = $random(seed) & 3;	// one of the four sources
		irq_bit   = data_t'(1) << k;
		bus_write(CTRL_ADDR, ~IRQ_MASK);	// upper bits set, enables off
		@(posedge clk_i);
		irq_src_i <= ~IRQ_MASK | irq_bit;	// dead bits rise too
		poll_read(IRQ_ADDR, irq_bit, "IRQ flag", got);
		check_data("IRQ read", got, irq_bit & IRQ_MASK);
		check_bit("irq_o", irq_o, 1'b0);	// flag set but not enabled
		bus_write(CTRL_ADDR, ~IRQ_MASK | irq_bit);	// enable source k only
		@(negedge clk_i);
		check_bit("irq_o", irq_o, 1'b1);
		bus_write(IRQ_ADDR, '0);	// zeros leave flags alone
		bus_read(IRQ_ADDR, got);
		check_data("IRQ after zero write", got, irq_bit & IRQ_MASK);
		bus_write(IRQ_ADDR, irq_bit);	// write one to clear
		bus_read(IRQ_ADDR, got);
		check_data("IRQ after clear", got, '0);
		check_bit("irq_o", irq_o, 1'b0);
		@(posedge clk_i);
		irq_src_i <= '0;
		bus_write(CTRL_ADDR, '0);
		report_test("IRQ set and clear", err_start);
	endtask

	task automatic evnt_clear_on_read();
		int    err_start;
		data_t val;
		data_t got;
		err_start = n_errors;
		val       = data_t'($random(seed)) & EVNT_MASK;
		if (val == '0) begin
			val = EVNT_MASK;	// need at least one event
		end
		@(posedge clk_i);
		evnt_i <= val;
		repeat (6) @(posedge clk_i);	// long enough for the resync chain
		evnt_i <= '0;
		repeat (8) @(posedge clk_i);	// flags must hold without a read
		bus_read(STAT_ADDR, got);	// other reads do not clear
		bus_read(EVNT_ADDR, got);
		check_data("EVNT first read", got, val);
		bus_read(EVNT_ADDR, got);
		check_data("EVNT after clear", got, '0);
		report_test("EVNT clear on read", err_start);
	endtask

	initial begin
		seed           = 32'haff5;
		rst_i          = 1'b1;
		rbus_addr_i    = IDLE_ADDR;
		rbus_wr_i      = 1'b0;
		rbus_rd_i      = 1'b0;
		rbus_wr_data_i = '0;
		stat_i         = '0;
		irq_src_i      = '0;
		evnt_i         = '0;
		repeat (5) @(posedge clk_i);
		rst_i <= 1'b0;
		reset_values();
		ctrl_rw();
		stat_ro();
		irq_set_clear();
		evnt_clear_on_read();
		repeat (2) @(posedge clk_i);	// let the last assertions settle
		n_errors += i_dut.u_checker.n_fail;
		$display("checks %0d, errors %0d, assertion failures %0d",
		         n_checks, n_errors, i_dut.u_checker.n_fail);
		if (n_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#200us;	// far beyond the longest run
		$display("timeout: simulation did not reach the end of the tests");
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
hw/rbus_pkg.sv
hw/reg_map_pkg.sv
hw/in_cond.sv
hw/hive_base_reg.sv
hw/periph_regs.sv
tests/periph_regs_checker.sv
tests/periph_regs_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run periph_regs_tb with Verilator, pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--top-module periph_regs_tb -f all.f &&
./obj_dir/Vperiph_regs_tb +verilator+error+limit+1000 | tee /dev/stderr \
	| grep "Done: no errors" > /dev/null &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
